//--- rtl/isaPkg.sv
`default_nettype none

package isaPkg;

    typedef logic [31:0] wordT;  // data or instruction word

    // opcode field in the top five bits of the instruction word
    typedef enum logic [4:0] {
        opLd   = 5'd0,
        opLdi  = 5'd1,
        opSt   = 5'd2,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opRor  = 5'd7,
        opRol  = 5'd8,
        opShr  = 5'd9,
        opShra = 5'd10,
        opShl  = 5'd11,
        opAddi = 5'd12,
        opAndi = 5'd13,
        opOri  = 5'd14,
        opDiv  = 5'd15,
        opMul  = 5'd16,
        opNeg  = 5'd17,
        opNot  = 5'd18,
        opBr   = 5'd19,  // conditional branch
        opJal  = 5'd20,
        opJr   = 5'd21,
        opMflo = 5'd24,  // 22 and 23 unused here
        opMfhi = 5'd25
    } opcodeT;

    // opcodes that share one step sequence share a class
    typedef enum logic [3:0] {
        classAluReg, classAluImm, classUnary, classMul, classDiv,
        classBranch, classJr, classJal, classMfhi, classMflo,
        classLoad, classStore, classIllegal
    } instrClassT;

    // encoded ALU operation select
    typedef enum logic [3:0] {
        aluNone, aluAdd, aluSub, aluAnd, aluOr, aluRor, aluRol,
        aluShr, aluShra, aluShl, aluMul, aluDiv, aluNeg, aluNot
    } aluOpT;

endpackage

`default_nettype wire

//--- rtl/controlPkg.sv
`default_nettype none

package controlPkg;

    import isaPkg::*;

    // one phase per clock with execute steps numbered as in the step table
    typedef enum logic [3:0] {
        phaseReset  = 4'd0,
        phaseFetch0 = 4'd1,
        phaseFetch1 = 4'd2,
        phaseFetch2 = 4'd3,
        phaseExec3  = 4'd4,
        phaseExec4  = 4'd5,
        phaseExec5  = 4'd6,
        phaseExec6  = 4'd7,
        phaseExec7  = 4'd8
    } phaseT;

    // last execute phase of each class
    function automatic phaseT execLength(instrClassT cls);
        case (cls)
            classAluReg, classAluImm, classUnary, classMul: begin
                return phaseExec5;  // operands, op, writeback
            end
            classDiv: begin
                return phaseExec6;  // extra step for LO
            end
            classBranch, classLoad, classStore: begin
                return phaseExec7;
            end
            classJal: begin
                return phaseExec4;  // link, then jump
            end
            default: begin
                return phaseExec3;  // jr, mfhi, mflo, illegal
            end
        endcase
    endfunction

endpackage

`default_nettype wire

//--- rtl/instrLatch.sv
`timescale 1ns/1ps
`default_nettype none

module instrLatch
    import isaPkg::*, controlPkg::*;
#(
    parameter int InstrWidth = 32
) (
    input  logic       Clock,
    input  logic       Reset,
    input  phaseT      phase,
    input  wordT       instruction,
    output instrClassT instrClass,
    output aluOpT      aluOp
);

    localparam int OpcodeLsb = InstrWidth - $bits(opcodeT);  // opcode sits in the top bits

    opcodeT     opcode;
    instrClassT decodedClass;
    aluOpT      decodedAluOp;

    assign opcode = opcodeT'(instruction[OpcodeLsb +: $bits(opcodeT)]);

    always_comb begin
        case (opcode)
            opAdd, opSub, opAnd, opOr, opRor, opRol, opShr, opShra, opShl: begin
                decodedClass = classAluReg;
            end
            opAddi, opAndi, opOri: decodedClass = classAluImm;
            opNeg, opNot:          decodedClass = classUnary;
            opMul:                 decodedClass = classMul;
            opDiv:                 decodedClass = classDiv;
            opBr:                  decodedClass = classBranch;
            opJr:                  decodedClass = classJr;
            opJal:                 decodedClass = classJal;
            opMfhi:                decodedClass = classMfhi;
            opMflo:                decodedClass = classMflo;
            opLd, opLdi:           decodedClass = classLoad;  // same steps for both
            opSt:                  decodedClass = classStore;
            default:               decodedClass = classIllegal;  // unused encodings
        endcase
    end

    always_comb begin
        case (opcode)
            opAdd, opAddi: decodedAluOp = aluAdd;  // immediate forms reuse the reg op
            opSub:         decodedAluOp = aluSub;
            opAnd, opAndi: decodedAluOp = aluAnd;
            opOr, opOri:   decodedAluOp = aluOr;
            opRor:         decodedAluOp = aluRor;
            opRol:         decodedAluOp = aluRol;
            opShr:         decodedAluOp = aluShr;
            opShra:        decodedAluOp = aluShra;
            opShl:         decodedAluOp = aluShl;
            opMul:         decodedAluOp = aluMul;
            opDiv:         decodedAluOp = aluDiv;
            opNeg:         decodedAluOp = aluNeg;
            opNot:         decodedAluOp = aluNot;
            default:       decodedAluOp = aluNone;  // address adds come from strobeGen
        endcase
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            instrClass <= classIllegal;
            aluOp      <= aluNone;
        end else if (phase == phaseFetch2) begin  // word is on the bus into IR
            instrClass <= decodedClass;
            aluOp      <= decodedAluOp;
        end
    end

    // register moves and jumps must not leave an ALU op latched for execute
    aluFreeExec: assert property (@(posedge Clock) disable iff (Reset)
        (phase >= phaseExec3 && instrClass inside {classJr, classMfhi, classMflo})
            |-> aluOp == aluNone);

endmodule

`default_nettype wire

//--- rtl/controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer
    import isaPkg::*, controlPkg::*;
(
    input  logic       Clock,
    input  logic       Reset,
    input  instrClassT instrClass,
    output phaseT      phase
);

    phaseT nextPhase;
    logic  lastStep;  // final execute phase of the current instruction

    assign lastStep = (phase >= phaseExec3) && (phase >= execLength(instrClass));

    always_comb begin
        nextPhase = phaseT'(phase + 4'd1);  // reset, fetch and execute all step by one
        if (lastStep) begin
            if (instrClass == classIllegal) begin
                nextPhase = phaseReset;  // bad opcode restarts from PC clear
            end else begin
                nextPhase = phaseFetch0;  // keep PC, fetch next word
            end
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            phase <= phaseReset;
        end else begin
            phase <= nextPhase;
        end
    end

    // counter must stay within the nine defined phases
    legalPhase: assert property (@(posedge Clock) disable iff (Reset)
        !$isunknown(phase) && phase <= phaseExec7);

endmodule

`default_nettype wire

//--- rtl/strobeGen.sv
`timescale 1ns/1ps
`default_nettype none

module strobeGen
    import isaPkg::*, controlPkg::*;
(
    input  phaseT      phase,
    input  instrClassT instrClass,
    input  aluOpT      aluOpIn,
    input  logic       conFlag,
    output logic       gra, grb, grc, rIn, rOut,
    output logic       clear, read, write,
    output logic       hiIn, loIn, conIn, pcIn, irIn, yIn, zIn,
    output logic       zHighIn, zLowIn, marIn, mdrIn,
    output logic       cOut, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut,
    output logic       incPc,
    output aluOpT      aluOp
);

    always_comb begin
        {gra, grb, grc, rIn, rOut, clear, read, write} = '0;
        {hiIn, loIn, conIn, pcIn, irIn, yIn, zIn} = '0;
        {zHighIn, zLowIn, marIn, mdrIn} = '0;
        {cOut, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut, incPc} = '0;
        aluOp = aluNone;

        case (phase)
            phaseReset: begin
                pcIn  = 1'b1;  // PC loads zero
                clear = 1'b1;
            end
            phaseFetch0: begin
                pcOut = 1'b1;  // PC to MAR, bump PC
                marIn = 1'b1;
                incPc = 1'b1;
            end
            phaseFetch1: begin
                read  = 1'b1;  // memory word into MDR
                mdrIn = 1'b1;
            end
            phaseFetch2: begin
                mdrOut = 1'b1;  // MDR to IR
                irIn   = 1'b1;
            end
            phaseExec3: begin
                case (instrClass)
                    classBranch: {gra, rOut, conIn} = 3'b111;  // condition test on Ra
                    classJr:     {gra, rOut, pcIn} = 3'b111;
                    classJal:    {pcOut, grb, rIn} = 3'b111;  // save return address
                    classMfhi:   {hiOut, gra, rIn} = 3'b111;
                    classMflo:   {loOut, gra, rIn} = 3'b111;
                    classIllegal: ;  // empty step before reset
                    default:     {grb, rOut, yIn} = 3'b111;  // Rb into Y
                endcase
            end
            phaseExec4: begin
                case (instrClass)
                    classAluReg: {grc, rOut, zIn} = 3'b111;
                    classAluImm: {cOut, zIn} = 2'b11;  // constant as second operand
                    classUnary:  zIn = 1'b1;
                    classMul, classDiv: {grc, rOut, zHighIn, zLowIn} = 4'b1111;
                    classBranch: {pcOut, yIn} = 2'b11;
                    classJal:    {gra, rOut, pcIn} = 3'b111;  // jump to Ra
                    classLoad, classStore: {cOut, zIn} = 2'b11;  // base plus offset
                    default: ;
                endcase
                case (instrClass)
                    classAluReg, classAluImm, classUnary, classMul, classDiv: begin
                        aluOp = aluOpIn;  // latched op
                    end
                    classLoad, classStore: aluOp = aluAdd;  // address calc
                    default: ;
                endcase
            end
            phaseExec5: begin
                case (instrClass)
                    classAluReg, classAluImm, classUnary, classMul: begin
                        {zLowOut, gra, rIn} = 3'b111;  // result to Ra
                    end
                    classDiv:    {zHighOut, hiIn} = 2'b11;  // remainder
                    classBranch: begin
                        {cOut, zIn} = 2'b11;  // PC plus offset
                        aluOp = aluAdd;
                    end
                    classLoad, classStore: {zLowOut, marIn} = 2'b11;
                    default: ;
                endcase
            end
            phaseExec6: begin
                case (instrClass)
                    classDiv:    {zLowOut, loIn} = 2'b11;  // quotient
                    classBranch: begin
                        zLowOut = conFlag;  // target on bus if taken
                        incPc   = !conFlag;
                    end
                    classLoad:   {read, mdrIn} = 2'b11;
                    classStore:  {gra, rOut, mdrIn} = 3'b111;  // store data into MDR
                    default: ;
                endcase
            end
            phaseExec7: begin
                case (instrClass)
                    classBranch: pcIn = conFlag;
                    classLoad:   {mdrOut, gra, rIn} = 3'b111;
                    classStore:  write = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // sampled on each phase change, so these see the settled strobes of the phase being left
    noReadWrite: assert property (@(phase) !(read && write));
    noRegInOut:  assert property (@(phase) !(rIn && rOut));  // one bus driver per step

endmodule

`default_nettype wire

//--- rtl/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit
    import isaPkg::*, controlPkg::*;
#(
    parameter int InstrWidth = 32
) (
    input  logic  Clock,
    input  logic  Reset,
    input  wordT  instruction,
    input  logic  conFlag,
    output logic  gra, grb, grc, rIn, rOut,
    output logic  clear, read, write,
    output logic  hiIn, loIn, conIn, pcIn, irIn, yIn, zIn,
    output logic  zHighIn, zLowIn, marIn, mdrIn,
    output logic  cOut, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut,
    output logic  incPc,
    output aluOpT aluOp
);

    phaseT      phase;       // current step
    instrClassT instrClass;  // latched at fetch2
    aluOpT      latchedAluOp;

    controlSequencer controlSequencer_i (
        .Clock      (Clock),
        .Reset      (Reset),
        .instrClass (instrClass),
        .phase      (phase)
    );

    instrLatch #(
        .InstrWidth (InstrWidth)
    ) instrLatch_i (
        .Clock       (Clock),
        .Reset       (Reset),
        .phase       (phase),
        .instruction (instruction),
        .instrClass  (instrClass),
        .aluOp       (latchedAluOp)
    );

    strobeGen strobeGen_i (
        .phase      (phase),
        .instrClass (instrClass),
        .aluOpIn    (latchedAluOp),
        .conFlag    (conFlag),
        .gra        (gra),
        .grb        (grb),
        .grc        (grc),
        .rIn        (rIn),
        .rOut       (rOut),
        .clear      (clear),
        .read       (read),
        .write      (write),
        .hiIn       (hiIn),
        .loIn       (loIn),
        .conIn      (conIn),
        .pcIn       (pcIn),
        .irIn       (irIn),
        .yIn        (yIn),
        .zIn        (zIn),
        .zHighIn    (zHighIn),
        .zLowIn     (zLowIn),
        .marIn      (marIn),
        .mdrIn      (mdrIn),
        .cOut       (cOut),
        .pcOut      (pcOut),
        .mdrOut     (mdrOut),
        .zHighOut   (zHighOut),
        .zLowOut    (zLowOut),
        .hiOut      (hiOut),
        .loOut      (loOut),
        .incPc      (incPc),
        .aluOp      (aluOp)
    );

endmodule

`default_nettype wire

//--- verification/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb
    import isaPkg::*;
();

    localparam int ClockPeriod = 20;  // ns
    localparam int ResetCycles = 8;
    localparam int WatchMargin = 40;  // spare cycles before the watchdog fires

    // step-sequence groups of the opcode list
    typedef enum {
        kindReg, kindImm, kindUnary, kindMul, kindDiv, kindBranch, kindJr,
        kindJal, kindMfhi, kindMflo, kindLoad, kindStore, kindBad
    } kindT;

    typedef struct packed {
        logic  gra, grb, grc, rIn, rOut, clear, read, write;
        logic  hiIn, loIn, conIn, pcIn, irIn, yIn, zIn;
        logic  zHighIn, zLowIn, marIn, mdrIn;
        logic  cOut, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut, incPc;
        aluOpT aluOp;
    } strobesT;

    logic  Clock, Reset, conFlag;
    wordT  instruction;
    logic  gra, grb, grc, rIn, rOut, clear, read, write;
    logic  hiIn, loIn, conIn, pcIn, irIn, yIn, zIn;
    logic  zHighIn, zLowIn, marIn, mdrIn;
    logic  cOut, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut, incPc;
    aluOpT aluOp;

    strobesT    actual;
    int         expStep;        // -1 reset, 0..2 fetch, 3..7 execute
    logic [4:0] curOp;          // opcode now in execute
    string      curName;
    logic       checking;
    int         errors = 0;
    int         checks = 0;
    int         budgetCycles = 0;
    integer     seed;
    logic [4:0] testOps[$];

    controlUnit #(.InstrWidth(32)) controlUnit_i (.*);

    assign actual = {gra, grb, grc, rIn, rOut, clear, read, write,
                     hiIn, loIn, conIn, pcIn, irIn, yIn, zIn,
                     zHighIn, zLowIn, marIn, mdrIn,
                     cOut, pcOut, mdrOut, zHighOut, zLowOut, hiOut, loOut, incPc, aluOp};

    initial begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    function automatic kindT kindOf(logic [4:0] op);
        case (op)
            opAdd, opSub, opAnd, opOr, opRor, opRol, opShr, opShra, opShl: return kindReg;
            opAddi, opAndi, opOri: return kindImm;
            opNeg, opNot:          return kindUnary;
            opMul:                 return kindMul;
            opDiv:                 return kindDiv;
            opBr:                  return kindBranch;
            opJr:                  return kindJr;
            opJal:                 return kindJal;
            opMfhi:                return kindMfhi;
            opMflo:                return kindMflo;
            opLd, opLdi:           return kindLoad;
            opSt:                  return kindStore;
            default:               return kindBad;  // 22, 23, 26..31
        endcase
    endfunction

    function automatic aluOpT aluOpFor(logic [4:0] op);
        case (op)
            opAdd, opAddi: return aluAdd;
            opSub:         return aluSub;
            opAnd, opAndi: return aluAnd;
            opOr, opOri:   return aluOr;
            opRor:         return aluRor;
            opRol:         return aluRol;
            opShr:         return aluShr;
            opShra:        return aluShra;
            opShl:         return aluShl;
            opMul:         return aluMul;
            opDiv:         return aluDiv;
            opNeg:         return aluNeg;
            opNot:         return aluNot;
            default:       return aluNone;
        endcase
    endfunction

    // last execute step number of an opcode
    function automatic int lastStep(logic [4:0] op);
        case (kindOf(op))
            kindReg, kindImm, kindUnary, kindMul: return 5;
            kindDiv:                              return 6;
            kindBranch, kindLoad, kindStore:      return 7;
            kindJal:                              return 4;
            default:                              return 3;  // jr, mfhi, mflo, illegal
        endcase
    endfunction

    // expected strobes and ALU select for one step of the step table
    function automatic strobesT expectedStrobes(int step, logic [4:0] op, logic flag);
        strobesT s;
        kindT    k;
        s = '0;  // aluOp zero is aluNone
        k = kindOf(op);
        case (step)
            -1: {s.pcIn, s.clear} = 2'b11;
            0:  {s.pcOut, s.marIn, s.incPc} = 3'b111;
            1:  {s.read, s.mdrIn} = 2'b11;
            2:  {s.mdrOut, s.irIn} = 2'b11;
            3: begin
                case (k)
                    kindBranch: {s.gra, s.rOut, s.conIn} = 3'b111;
                    kindJr:     {s.gra, s.rOut, s.pcIn} = 3'b111;
                    kindJal:    {s.pcOut, s.grb, s.rIn} = 3'b111;
                    kindMfhi:   {s.hiOut, s.gra, s.rIn} = 3'b111;
                    kindMflo:   {s.loOut, s.gra, s.rIn} = 3'b111;
                    kindBad:    s = '0;  // empty step
                    default:    {s.grb, s.rOut, s.yIn} = 3'b111;
                endcase
            end
            4: begin
                case (k)
                    kindReg:   {s.grc, s.rOut, s.zIn} = 3'b111;
                    kindImm:   {s.cOut, s.zIn} = 2'b11;
                    kindUnary: s.zIn = 1'b1;
                    kindMul, kindDiv: {s.grc, s.rOut, s.zHighIn, s.zLowIn} = 4'b1111;
                    kindBranch: {s.pcOut, s.yIn} = 2'b11;
                    kindJal:    {s.gra, s.rOut, s.pcIn} = 3'b111;
                    kindLoad, kindStore: {s.cOut, s.zIn} = 2'b11;
                    default: ;
                endcase
                if (k inside {kindReg, kindImm, kindUnary, kindMul, kindDiv}) begin
                    s.aluOp = aluOpFor(op);
                end else if (k inside {kindLoad, kindStore}) begin
                    s.aluOp = aluAdd;  // base plus offset
                end
            end
            5: begin
                case (k)
                    kindReg, kindImm, kindUnary, kindMul: {s.zLowOut, s.gra, s.rIn} = 3'b111;
                    kindDiv:    {s.zHighOut, s.hiIn} = 2'b11;
                    kindBranch: {s.cOut, s.zIn, s.aluOp} = {2'b11, aluAdd};
                    kindLoad, kindStore: {s.zLowOut, s.marIn} = 2'b11;
                    default: ;
                endcase
            end
            6: begin
                case (k)
                    kindDiv:    {s.zLowOut, s.loIn} = 2'b11;
                    kindBranch: {s.zLowOut, s.incPc} = {flag, !flag};  // taken or skip
                    kindLoad:   {s.read, s.mdrIn} = 2'b11;
                    kindStore:  {s.gra, s.rOut, s.mdrIn} = 3'b111;
                    default: ;
                endcase
            end
            7: begin
                case (k)
                    kindBranch: s.pcIn = flag;
                    kindLoad:   {s.mdrOut, s.gra, s.rIn} = 3'b111;
                    kindStore:  s.write = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
        return s;
    endfunction

    function automatic string stepName(int step);
        if (step < 0) begin
            return "reset";
        end
        return (step < 3) ? $sformatf("fetch%0d", step) : $sformatf("exec%0d", step);
    endfunction

    function automatic string opName(logic [4:0] op);
        opcodeT code;
        code = opcodeT'(op);
        if (kindOf(op) == kindBad) begin
            return $sformatf("illegal%0d", op);
        end
        return code.name();
    endfunction

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actualValue);
        checks++;
        if (actualValue !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", testName, expected, actualValue);
        end
    endtask

    task automatic stepTo(input int step);  // one clock into the given step
        @(posedge Clock);
        expStep <= step;
    endtask

    task automatic runInstruction(input logic [4:0] op);
        int last;
        last = lastStep(op);
        stepTo(0);
        curOp   <= op;
        curName <= opName(op);
        stepTo(1);
        stepTo(2);
        instruction <= {op, 27'($random(seed))};  // held through fetch2
        conFlag     <= 1'($random(seed));  // only branches look at it
        for (int s = 3; s <= last; s++) begin
            stepTo(s);
        end
        if (kindOf(op) == kindBad) begin
            stepTo(-1);  // illegal goes back through PC clear
        end
    endtask

    // compare at the falling edge when strobes have settled from the rising one
    always @(negedge Clock) begin
        if (checking) begin
            checkValue({curName, " ", stepName(expStep)},
                       32'(expectedStrobes(expStep, curOp, conFlag)), 32'(actual));
            checkValue({curName, " read/write overlap"}, 32'd0, 32'(read & write));
        end
    end

    initial begin
        Reset       = 1'b1;
        instruction = '0;
        conFlag     = 1'b0;
        checking    = 1'b0;
        expStep     = -1;
        curOp       = '0;
        curName     = "reset";
        seed        = 32'h0be6e64e;
        testOps = '{opAdd, opSub, opAnd, opOr, opRor, opRol, opShr, opShra, opShl,
                    opAddi, opAndi, opOri, opNeg, opNot, opMul, opDiv,
                    opBr, opBr, opBr, opBr, opBr, opBr,
                    opLd, opLdi, opSt, opJr, opJal, opMfhi, opMflo,
                    5'd22, opAdd, 5'd23, 5'd30, opBr, opLd};
        budgetCycles = ResetCycles + WatchMargin;
        foreach (testOps[i]) begin
            budgetCycles += lastStep(testOps[i]) + 2;  // fetch, execute, maybe reset
        end
        repeat (ResetCycles) @(posedge Clock);
        Reset    <= 1'b0;
        checking <= 1'b1;
        foreach (testOps[i]) begin
            runInstruction(testOps[i]);
        end
        @(posedge Clock);
        checking <= 1'b0;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog sized from the instruction list
    initial begin
        wait (budgetCycles > 0);
        #(budgetCycles * ClockPeriod);
        $display("ERROR: watchdog expired after %0d cycles, the run hung", budgetCycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- controlUnit.f
rtl/isaPkg.sv
rtl/controlPkg.sv
rtl/instrLatch.sv
rtl/controlSequencer.sv
rtl/strobeGen.sv
rtl/controlUnit.sv
verification/controlUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= controlUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
